//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // request operation
    typedef enum logic [1:0] {
        op_lookup,
        op_store,
        op_refill
    } dcache_op_e;

    // byte address
    localparam int ADDR_W = 32;

    localparam int WORD_W = 32;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W/8-1:0] strb_t;

    // two ways only, the lru scheme is a single bit
    localparam int WAYS = 2;

    // default geometry, 128 sets of 8 words
    localparam int DEF_INDEX_W = 7;
    localparam int DEF_WORDS = 8;

endpackage

`default_nettype wire

//--- design/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

// array read, index in and per-way results one cycle later
interface array_rd_if #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - $clog2(WORDS) - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef word_t [WORDS-1:0] line_t;

    logic [INDEX_W-1:0] index;
    logic en;

    // set the read data below belongs to
    logic [INDEX_W-1:0] index_q;
    tag_t [WAYS-1:0] tag;
    logic [WAYS-1:0] valid;
    logic [WAYS-1:0] dirty;
    line_t [WAYS-1:0] line;
    logic lru;

    modport req (output index, en);
    modport mem (input index, en, output index_q, tag, valid, dirty, line, lru);
    modport hit (input index_q, tag, valid, dirty, line, lru);
endinterface

// array write, takes effect at the clock edge
interface array_wr_if #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - $clog2(WORDS) - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef word_t [WORDS-1:0] line_t;

    logic [INDEX_W-1:0] index;
    logic way;
    logic tag_we;
    tag_t tag;
    logic line_we;
    line_t line;
    logic [WORDS-1:0] word_we;
    strb_t strb;
    logic valid_we;
    logic dirty_we;
    logic dirty;
    logic lru_we;
    logic lru;

    modport src (output index, way, tag_we, tag, line_we, line, word_we, strb,
                 valid_we, dirty_we, dirty, lru_we, lru);
    modport mem (input index, way, tag_we, tag, line_we, line, word_we, strb,
                 valid_we, dirty_we, dirty, lru_we, lru);
endinterface

`default_nettype wire

//--- design/set_ram.sv
`timescale 1ns/1ps
`default_nettype none

module set_ram #(
    parameter int DEPTH_W = 7,
    parameter type entry_t = logic
) (
    input  logic               clk,
    input  logic               we,
    input  logic [DEPTH_W-1:0] waddr,
    input  entry_t             wdata,
    input  logic [DEPTH_W-1:0] raddr,
    output entry_t             rdata
);

    entry_t mem [2**DEPTH_W];

    // read returns the old entry when both ports hit the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- design/dcache_request.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_request #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS,
    localparam int OFF_W = $clog2(WORDS),
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - OFF_W - 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  dcache_pkg::dcache_op_e          req_op,
    input  logic [dcache_pkg::ADDR_W-1:0]   req_addr,
    input  dcache_pkg::word_t               req_wdata,
    input  dcache_pkg::strb_t               req_strb,
    input  dcache_pkg::word_t [WORDS-1:0]   req_line,
    output logic                            req_ready,
    output logic                            s1_valid,
    output dcache_pkg::dcache_op_e          s1_op,
    output logic [TAG_W-1:0]                s1_tag,
    output logic [OFF_W-1:0]                s1_word,
    output dcache_pkg::word_t               s1_wdata,
    output dcache_pkg::strb_t               s1_strb,
    output dcache_pkg::word_t [WORDS-1:0]   s1_line,
    array_rd_if.req                         rd
);
    import dcache_pkg::*;

    logic accept;
    logic stall_q;

    assign accept = req_valid && req_ready;

    // a write needs one cycle to land before the next read of its set
    assign req_ready = !stall_q;

    // address split: tag | index | word | byte
    assign rd.index = req_addr[OFF_W+2 +: INDEX_W];
    assign rd.en = accept;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            stall_q <= accept && (req_op != op_lookup);
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op <= req_op;
            s1_tag <= req_addr[ADDR_W-1 -: TAG_W];
            s1_word <= req_addr[2 +: OFF_W];
            s1_wdata <= req_wdata;
            s1_strb <= req_strb;
            s1_line <= req_line;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS
) (
    input logic     clk,
    input logic     rst_n,
    array_rd_if.mem rd,
    array_wr_if.mem wr
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - $clog2(WORDS) - 2;
    localparam int SETS = 2**INDEX_W;

    typedef logic [TAG_W-1:0] tag_t;
    typedef word_t [WORDS-1:0] line_t;

    logic [WAYS-1:0][SETS-1:0] valid_q;
    line_t line_wdata;
    logic lru_ram;
    logic lru_we_q;
    logic [INDEX_W-1:0] lru_index_q;
    logic lru_data_q;

    // byte merge against the line read for this same set last cycle
    always_comb begin
        for (int i = 0; i < WORDS; i++) begin
            for (int b = 0; b < WORD_W/8; b++) begin
                line_wdata[i][8*b +: 8] = (wr.word_we[i] && wr.strb[b]) ?
                    wr.line[i][8*b +: 8] : rd.line[wr.way][i][8*b +: 8];
            end
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        set_ram #(.DEPTH_W(INDEX_W), .entry_t(tag_t)) u_tag (
            .clk   (clk),
            .we    (wr.tag_we && (wr.way == 1'(w))),
            .waddr (wr.index),
            .wdata (wr.tag),
            .raddr (rd.index),
            .rdata (rd.tag[w])
        );

        set_ram #(.DEPTH_W(INDEX_W), .entry_t(logic)) u_dirty (
            .clk   (clk),
            .we    (wr.dirty_we && (wr.way == 1'(w))),
            .waddr (wr.index),
            .wdata (wr.dirty),
            .raddr (rd.index),
            .rdata (rd.dirty[w])
        );

        set_ram #(.DEPTH_W(INDEX_W), .entry_t(line_t)) u_line (
            .clk   (clk),
            .we    (wr.line_we && (wr.way == 1'(w))),
            .waddr (wr.index),
            .wdata (line_wdata),
            .raddr (rd.index),
            .rdata (rd.line[w])
        );
    end

    set_ram #(.DEPTH_W(INDEX_W), .entry_t(logic)) u_lru (
        .clk   (clk),
        .we    (wr.lru_we),
        .waddr (wr.index),
        .wdata (wr.lru),
        .raddr (rd.index),
        .rdata (lru_ram)
    );

    // valid bits, read like the rams
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            rd.valid <= '0;
            lru_we_q <= 1'b0;
        end else begin
            if (wr.valid_we) begin
                valid_q[wr.way][wr.index] <= 1'b1;
            end
            if (rd.en) begin
                for (int w = 0; w < WAYS; w++) begin
                    rd.valid[w] <= valid_q[w][rd.index];
                end
            end
            lru_we_q <= wr.lru_we;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd.index_q <= rd.index;
        end
        lru_index_q <= wr.index;
        lru_data_q <= wr.lru;
    end

    // ram missed the lru write on the same edge as the read
    assign rd.lru = (lru_we_q && (lru_index_q == rd.index_q)) ? lru_data_q : lru_ram;

endmodule

`default_nettype wire

//--- design/dcache_hit.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_hit #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS,
    localparam int OFF_W = $clog2(WORDS),
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - OFF_W - 2
) (
    input  logic                            s1_valid,
    input  dcache_pkg::dcache_op_e          s1_op,
    input  logic [TAG_W-1:0]                s1_tag,
    input  logic [OFF_W-1:0]                s1_word,
    input  dcache_pkg::word_t               s1_wdata,
    input  dcache_pkg::strb_t               s1_strb,
    input  dcache_pkg::word_t [WORDS-1:0]   s1_line,
    array_rd_if.hit                         rd,
    array_wr_if.src                         wr,
    output logic                            resp_valid,
    output dcache_pkg::dcache_op_e          resp_op,
    output logic                            resp_hit,
    output dcache_pkg::word_t               resp_rdata,
    output logic [TAG_W-1:0]                resp_victim_tag,
    output logic                            resp_victim_dirty,
    output dcache_pkg::word_t [WORDS-1:0]   resp_victim_line
);
    import dcache_pkg::*;

    logic [WAYS-1:0] hit_way;
    logic any_hit;
    logic hw;
    logic victim;
    logic is_refill;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = rd.valid[w] && (rd.tag[w] == s1_tag);
        end
    end

    assign any_hit = |hit_way;
    assign hw = hit_way[1];
    assign victim = rd.lru;
    assign is_refill = (s1_op == op_refill);

    assign resp_valid = s1_valid;
    assign resp_op = s1_op;
    assign resp_hit = any_hit && !is_refill;
    assign resp_rdata = resp_hit ? rd.line[hw][s1_word] : '0;

    // victim report only for a refill; an invalid way is never dirty
    assign resp_victim_tag = is_refill ? rd.tag[victim] : '0;
    assign resp_victim_dirty = is_refill && rd.valid[victim] && rd.dirty[victim];
    assign resp_victim_line = is_refill ? rd.line[victim] : '0;

    always_comb begin
        wr.index = rd.index_q;
        wr.way = hw;
        wr.tag_we = 1'b0;
        wr.tag = s1_tag;
        wr.line_we = 1'b0;
        wr.line = {WORDS{s1_wdata}};
        wr.word_we = '0;
        wr.strb = s1_strb;
        wr.valid_we = 1'b0;
        wr.dirty_we = 1'b0;
        wr.dirty = 1'b1;
        wr.lru_we = 1'b0;
        wr.lru = !hw;
        if (s1_valid) begin
            case (s1_op)
                op_lookup: begin
                    wr.lru_we = any_hit;
                end
                op_store: begin
                    // strobed word write into the hit way
                    wr.lru_we = any_hit;
                    wr.line_we = any_hit;
                    wr.word_we[s1_word] = 1'b1;
                    wr.dirty_we = any_hit;
                end
                op_refill: begin
                    wr.way = victim;
                    wr.tag_we = 1'b1;
                    wr.line_we = 1'b1;
                    wr.line = s1_line;
                    wr.word_we = '1;
                    wr.strb = '1;
                    wr.valid_we = 1'b1;
                    wr.dirty_we = 1'b1;
                    wr.dirty = 1'b0;
                    wr.lru_we = 1'b1;
                    wr.lru = !victim;
                end
                default: begin
                    wr.lru_we = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W,
    parameter int WORDS = dcache_pkg::DEF_WORDS,
    localparam int OFF_W = $clog2(WORDS),
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - OFF_W - 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  dcache_pkg::dcache_op_e          req_op,
    input  logic [dcache_pkg::ADDR_W-1:0]   req_addr,
    input  dcache_pkg::word_t               req_wdata,
    input  dcache_pkg::strb_t               req_strb,
    input  dcache_pkg::word_t [WORDS-1:0]   req_line,
    output logic                            req_ready,
    output logic                            resp_valid,
    output dcache_pkg::dcache_op_e          resp_op,
    output logic                            resp_hit,
    output dcache_pkg::word_t               resp_rdata,
    output logic [TAG_W-1:0]                resp_victim_tag,
    output logic                            resp_victim_dirty,
    output dcache_pkg::word_t [WORDS-1:0]   resp_victim_line
);

    logic s1_valid;
    dcache_pkg::dcache_op_e s1_op;
    logic [TAG_W-1:0] s1_tag;
    logic [OFF_W-1:0] s1_word;
    dcache_pkg::word_t s1_wdata;
    dcache_pkg::strb_t s1_strb;
    dcache_pkg::word_t [WORDS-1:0] s1_line;

    array_rd_if #(.INDEX_W(INDEX_W), .WORDS(WORDS)) rd_bus ();
    array_wr_if #(.INDEX_W(INDEX_W), .WORDS(WORDS)) wr_bus ();

    dcache_request #(.INDEX_W(INDEX_W), .WORDS(WORDS)) u_request (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_strb  (req_strb),
        .req_line  (req_line),
        .req_ready (req_ready),
        .s1_valid  (s1_valid),
        .s1_op     (s1_op),
        .s1_tag    (s1_tag),
        .s1_word   (s1_word),
        .s1_wdata  (s1_wdata),
        .s1_strb   (s1_strb),
        .s1_line   (s1_line),
        .rd        (rd_bus)
    );

    dcache_arrays #(.INDEX_W(INDEX_W), .WORDS(WORDS)) u_arrays (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (rd_bus),
        .wr    (wr_bus)
    );

    dcache_hit #(.INDEX_W(INDEX_W), .WORDS(WORDS)) u_hit (
        .s1_valid          (s1_valid),
        .s1_op             (s1_op),
        .s1_tag            (s1_tag),
        .s1_word           (s1_word),
        .s1_wdata          (s1_wdata),
        .s1_strb           (s1_strb),
        .s1_line           (s1_line),
        .rd                (rd_bus),
        .wr                (wr_bus),
        .resp_valid        (resp_valid),
        .resp_op           (resp_op),
        .resp_hit          (resp_hit),
        .resp_rdata        (resp_rdata),
        .resp_victim_tag   (resp_victim_tag),
        .resp_victim_dirty (resp_victim_dirty),
        .resp_victim_line  (resp_victim_line)
    );

endmodule

`default_nettype wire

//--- test/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int INDEX_W = DEF_INDEX_W;
    localparam int WORDS = DEF_WORDS;
    localparam int OFF_W = $clog2(WORDS);
    localparam int TAG_W = ADDR_W - INDEX_W - OFF_W - 2;
    localparam int CLK_NS = 8;
    localparam int RESET_CYC = 8;
    localparam int REQ_TOTAL = 81;
    localparam int WATCHDOG_NS = (REQ_TOTAL * 4 + RESET_CYC) * CLK_NS;

    typedef word_t [WORDS-1:0] line_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        dcache_op_e op;
        logic       hit;
        word_t      rdata;
        tag_t       vtag;
        logic       vdirty;
        line_t      vline;
        logic       vcheck;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic req_valid;
    dcache_op_e req_op;
    logic [ADDR_W-1:0] req_addr;
    word_t req_wdata;
    strb_t req_strb;
    line_t req_line;
    logic req_ready;
    logic resp_valid;
    dcache_op_e resp_op;
    logic resp_hit;
    word_t resp_rdata;
    tag_t resp_victim_tag;
    logic resp_victim_dirty;
    line_t resp_victim_line;

    int seed = 32'hed63_4395;
    int errors = 0;
    int err_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    bit acc_q = 1'b0;
    bit wr_q = 1'b0;
    exp_t cur;
    exp_t exp_q[$];

    // reference model keyed by set*2 + slot
    tag_t m_tag[int];
    bit m_valid[int];
    bit m_dirty[int];
    line_t m_line[int];
    bit m_lru[int];

    always #(CLK_NS / 2) clk = ~clk;

    dcache_top #(.INDEX_W(INDEX_W), .WORDS(WORDS)) dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (req_valid),
        .req_op            (req_op),
        .req_addr          (req_addr),
        .req_wdata         (req_wdata),
        .req_strb          (req_strb),
        .req_line          (req_line),
        .req_ready         (req_ready),
        .resp_valid        (resp_valid),
        .resp_op           (resp_op),
        .resp_hit          (resp_hit),
        .resp_rdata        (resp_rdata),
        .resp_victim_tag   (resp_victim_tag),
        .resp_victim_dirty (resp_victim_dirty),
        .resp_victim_line  (resp_victim_line)
    );

    function automatic bit slot_valid(int k);
        return m_valid.exists(k) && m_valid[k];
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(tag_t tag, int set, int word);
        return {tag, INDEX_W'(set), OFF_W'(word), 2'b00};
    endfunction

    // queue the expected response of one accepted request
    task automatic model_accept(dcache_op_e op, logic [ADDR_W-1:0] addr, word_t wdata,
                                strb_t strb, line_t line);
        int set;
        int word;
        int hs;
        int k;
        bit v;
        tag_t tag;
        line_t tmp;
        exp_t e;
        set = int'(addr[OFF_W+2 +: INDEX_W]);
        word = int'(addr[2 +: OFF_W]);
        tag = addr[ADDR_W-1 -: TAG_W];
        hs = -1;
        for (int s = 0; s < 2; s++) begin
            if (slot_valid(set * 2 + s) && m_tag[set * 2 + s] == tag) begin
                hs = s;
            end
        end
        e = '0;
        e.op = op;
        e.vcheck = 1'b1;
        k = set * 2 + hs;
        if (op == op_lookup && hs >= 0) begin
            e.hit = 1'b1;
            e.rdata = m_line[k][word];
            m_lru[set] = (hs == 0);
        end else if (op == op_store && hs >= 0) begin
            e.hit = 1'b1;
            tmp = m_line[k];
            e.rdata = tmp[word];
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (strb[b]) begin
                    tmp[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            m_line[k] = tmp;
            m_dirty[k] = 1'b1;
            m_lru[set] = (hs == 0);
        end else if (op == op_refill) begin
            v = m_lru.exists(set) ? m_lru[set] : 1'b0;
            k = set * 2 + int'(v);
            // an empty slot has no victim contents worth comparing
            if (slot_valid(k)) begin
                e.vtag = m_tag[k];
                e.vdirty = m_dirty[k];
                e.vline = m_line[k];
            end else begin
                e.vcheck = 1'b0;
            end
            m_tag[k] = tag;
            m_line[k] = line;
            m_valid[k] = 1'b1;
            m_dirty[k] = 1'b0;
            m_lru[set] = ~v;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_field(string name, logic [255:0] expv, logic [255:0] actv);
        assert (actv == expv) else begin
            errors++;
            $display("Error: %0t %s expected %0h got %0h", $time, name, expv, actv);
        end
    endtask

    // handshake and response checks at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (resp_valid == acc_q) else begin
                errors++;
                $display("Error: %0t resp_valid expected %0b got %0b", $time, acc_q, resp_valid);
            end
            assert (req_ready == !wr_q) else begin
                errors++;
                $display("Error: %0t req_ready expected %0b got %0b", $time, !wr_q, req_ready);
            end
            if (resp_valid && exp_q.size() == 0) begin
                errors++;
                $display("response at %0t with no request outstanding", $time);
            end else if (resp_valid) begin
                cur = exp_q.pop_front();
                check_field("resp_op", 256'(cur.op), 256'(resp_op));
                check_field("resp_hit", 256'(cur.hit), 256'(resp_hit));
                check_field("resp_rdata", 256'(cur.rdata), 256'(resp_rdata));
                check_field("resp_victim_dirty", 256'(cur.vdirty), 256'(resp_victim_dirty));
                if (cur.vcheck) begin
                    check_field("resp_victim_tag", 256'(cur.vtag), 256'(resp_victim_tag));
                    check_field("resp_victim_line", 256'(cur.vline), 256'(resp_victim_line));
                end
            end
            acc_q = req_valid && req_ready;
            wr_q = acc_q && (req_op != op_lookup);
            if (acc_q) begin
                model_accept(req_op, req_addr, req_wdata, req_strb, req_line);
            end
        end
    end

    task automatic send(dcache_op_e op, logic [ADDR_W-1:0] addr, word_t wdata,
                        strb_t strb, line_t line);
        req_valid <= 1'b1;
        req_op <= op;
        req_addr <= addr;
        req_wdata <= wdata;
        req_strb <= strb;
        req_line <= line;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic lookup(tag_t tag, int set, int word);
        send(op_lookup, addr_of(tag, set, word), '0, '0, '0);
    endtask

    task automatic store(tag_t tag, int set, int word, word_t d, strb_t s);
        send(op_store, addr_of(tag, set, word), d, s, '0);
    endtask

    task automatic refill(tag_t tag, int set);
        line_t l;
        for (int i = 0; i < WORDS; i++) begin
            l[i] = $random(seed);
        end
        send(op_refill, addr_of(tag, set, 0), '0, '0, l);
    endtask

    task automatic idle(int n);
        req_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic end_test(string name);
        idle(3);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_op = op_lookup;
        req_addr = '0;
        req_wdata = '0;
        req_strb = '0;
        req_line = '0;
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 16; i++) begin
            send(op_lookup, $random(seed), '0, '0, '0);
        end
        end_test("lookup after reset");

        refill(20'h1_2345, 5);
        for (int w = 0; w < WORDS; w++) begin
            lookup(20'h1_2345, 5, w);
        end
        end_test("refill then lookup");

        for (int i = 0; i < 4; i++) begin
            store(20'h1_2345, 5, (i * 3 + 1) % WORDS, $random(seed), 4'($random(seed)));
            lookup(20'h1_2345, 5, (i * 3 + 1) % WORDS);
        end
        store(20'h2_2345, 5, 0, $random(seed), 4'hf);
        lookup(20'h2_2345, 5, 0);
        // resident line of the set must not see the missed store
        lookup(20'h1_2345, 5, 0);
        store(20'h1_2345, 21, 3, $random(seed), 4'hf);
        end_test("store hit and miss");

        // b is made dirty and the hit on a leaves b as the victim
        for (int set = 9; set < 50; set += 31) begin
            refill(20'hA_0000 + 20'(set), set);
            refill(20'hB_0000 + 20'(set), set);
            store(20'hB_0000 + 20'(set), set, 3, $random(seed), 4'($random(seed)));
            lookup(20'hA_0000 + 20'(set), set, 0);
            refill(20'hC_0000 + 20'(set), set);
            refill(20'hD_0000 + 20'(set), set);
            lookup(20'hC_0000 + 20'(set), set, 1);
            lookup(20'hD_0000 + 20'(set), set, 2);
            lookup(20'hA_0000 + 20'(set), set, 0);
            lookup(20'hB_0000 + 20'(set), set, 3);
        end
        end_test("victim after two refills");

        // refill streams right behind lookup hits in its set
        for (int i = 0; i < 4; i++) begin
            refill(20'h5_0000 + 20'(i), 12 + 17 * i);
            refill(20'h6_0000 + 20'(i), 12 + 17 * i);
            lookup(20'h6_0000 + 20'(i), 12 + 17 * i, 4);
            lookup(20'h5_0000 + 20'(i), 12 + 17 * i, 5);
            refill(20'h7_0000 + 20'(i), 12 + 17 * i);
            lookup(20'h7_0000 + 20'(i), 12 + 17 * i, 6);
        end
        end_test("ready and lru forwarding");

        idle(4);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_q.size());
        end
        $display("summary: %0d tests ok, %0d tests with mismatches, %0d errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/dcache_pkg.sv
design/dcache_if.sv
design/set_ram.sv
design/dcache_request.sv
design/dcache_arrays.sv
design/dcache_hit.sv
design/dcache_top.sv
test/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_dcache \
    -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1
